// File: logic/ex_params.svh
////////////////////////////////////////////////////////////////////////////
// Execute stage parameters
// Data width, register address width and the special register counts
// shared by the package and the execute stage modules
////////////////////////////////////////////////////////////////////////////

`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Data word width
`define EX_XLEN 32

// Register file address width, covers integer and extended registers
`define EX_RADDR_W 6

// Special register counts for the dot-product extension
`define EX_NUM_WSPR 4 // Weight registers
`define EX_NUM_ASPR 2 // Activation registers

`endif

// File: logic/ex_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage types
// Operation codes and the packed request, SPR select and register-file
// write port structures used across the execute stage
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_params.svh"

package ex_pkg;

  // ALU operations, the last four drive the branch compare
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE
  } alu_op_e;

  typedef enum logic [1:0] {
    MULT_MUL,  // Low word, single cycle
    MULT_MULH, // Signed high word, two cycles
    MULT_SDOT  // 4x8 signed dot product plus accumulator
  } mult_op_e;

  typedef struct packed {
    alu_op_e            op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
  } alu_req_t;

  typedef struct packed {
    mult_op_e           op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_XLEN-1:0] c; // Accumulator, also the jump target field
  } mult_req_t;

  // Load target in the SPR bank, indices also pick the dot operands
  typedef struct packed {
    logic                             w_en;
    logic [$clog2(`EX_NUM_WSPR)-1:0]  w_idx;
    logic                             a_en;
    logic [$clog2(`EX_NUM_ASPR)-1:0]  a_idx;
  } spr_sel_t;

  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] addr;
    logic [`EX_XLEN-1:0]    data;
  } wb_port_t;

endpackage

`default_nettype wire

// File: logic/ex_alu.sv
////////////////////////////////////////////////////////////////////////////
// Integer ALU
// Add, subtract, logic, shift left and set-less-than, plus the four
// branch compares that feed the branch decision
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_params.svh"

module ex_alu import ex_pkg::*; (
  input  alu_req_t            req_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_o
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (req_i.a == req_i.b);
  assign lt_s = ($signed(req_i.a) < $signed(req_i.b));
  assign lt_u = (req_i.a < req_i.b);

  // Branch compares
  always_comb begin
    case (req_i.op)
      ALU_EQ:  cmp_o = eq;
      ALU_NE:  cmp_o = ~eq;
      ALU_LT:  cmp_o = lt_s;
      ALU_GE:  cmp_o = ~lt_s;
      default: cmp_o = 1'b0;
    endcase
  end

  always_comb begin
    case (req_i.op)
      ALU_ADD:  result_o = req_i.a + req_i.b;
      ALU_SUB:  result_o = req_i.a - req_i.b;
      ALU_AND:  result_o = req_i.a & req_i.b;
      ALU_OR:   result_o = req_i.a | req_i.b;
      ALU_XOR:  result_o = req_i.a ^ req_i.b;
      ALU_SLL:  result_o = req_i.a << req_i.b[SHAMT_W-1:0];
      ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
      default:  result_o = {{(`EX_XLEN-1){1'b0}}, cmp_o}; // Compares
    endcase
  end

endmodule

`default_nettype wire

// File: logic/ex_dotp_mult.sv
////////////////////////////////////////////////////////////////////////////
// Multiplier with dot-product support
// MUL and SDOT finish in one cycle, MULH holds the signed 64-bit product
// for a second cycle and stalls the stage meanwhile
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_params.svh"

module ex_dotp_mult import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en_i,
  input  mult_req_t           req_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                multicycle_o,
  output logic                ready_o
);

  localparam int LANES = `EX_XLEN / 8;

  logic signed [2*`EX_XLEN-1:0] prod_full;
  logic        [2*`EX_XLEN-1:0] prod_q;   // Held MULH product
  logic                         mulh_q;   // Set in the second MULH cycle
  logic        [`EX_XLEN-1:0]   dot_sum;

  // One signed multiplier, low word also serves MUL
  assign prod_full = $signed(req_i.a) * $signed(req_i.b);

  // Byte lanes, each product sign extended before the sum
  always_comb begin
    logic signed [15:0] lane_prod;
    dot_sum = req_i.c;
    for (int i = 0; i < LANES; i++) begin
      lane_prod = $signed(req_i.a[8*i +: 8]) * $signed(req_i.b[8*i +: 8]);
      dot_sum   = dot_sum + {{(`EX_XLEN-16){lane_prod[15]}}, lane_prod};
    end
  end

  assign multicycle_o = en_i & (req_i.op == MULT_MULH) & ~mulh_q;
  assign ready_o      = ~multicycle_o;

  ////////////////////////////////////////////////////////////////////////////
  // MULH state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_q <= 1'b0;
    end else if (multicycle_o) begin
      mulh_q <= 1'b1;
    end else if (ex_ready_i) begin
      mulh_q <= 1'b0; // Back to idle once the result leaves
    end
  end

  always_ff @(posedge clk) begin
    if (multicycle_o) begin
      prod_q <= prod_full;
    end
  end

  always_comb begin
    case (req_i.op)
      MULT_MULH: result_o = prod_q[2*`EX_XLEN-1:`EX_XLEN];
      MULT_SDOT: result_o = dot_sum;
      default:   result_o = prod_full[`EX_XLEN-1:0];
    endcase
  end

endmodule

`default_nettype wire

// File: logic/ex_spr_bank.sv
////////////////////////////////////////////////////////////////////////////
// Special register bank for the dot-product extension
// Weight and activation registers, written from load data in the WB
// cycle and read as dot-product operands by the instruction in EX
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_params.svh"

module ex_spr_bank import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_en_i,
  input  spr_sel_t            wr_sel_i,
  input  logic [`EX_XLEN-1:0] wr_data_i,
  input  spr_sel_t            rd_sel_i,
  output logic [`EX_XLEN-1:0] wspr_o,
  output logic [`EX_XLEN-1:0] aspr_o
);

  logic [`EX_NUM_WSPR-1:0][`EX_XLEN-1:0] wspr_q;
  logic [`EX_NUM_ASPR-1:0][`EX_XLEN-1:0] aspr_q;

  // Both kinds may be loaded by the same instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wspr_q <= '0;
      aspr_q <= '0;
    end else if (wr_en_i) begin
      if (wr_sel_i.w_en) begin
        wspr_q[wr_sel_i.w_idx] <= wr_data_i;
      end
      if (wr_sel_i.a_en) begin
        aspr_q[wr_sel_i.a_idx] <= wr_data_i;
      end
    end
  end

  assign wspr_o = wspr_q[rd_sel_i.w_idx]; // Operand b of an SPR dot product
  assign aspr_o = aspr_q[rd_sel_i.a_idx]; // Operand a

endmodule

`default_nettype wire

// File: logic/ex_writeback.sv
////////////////////////////////////////////////////////////////////////////
// EX/WB pipeline register
// Carries the load destination and SPR select into WB, keeps the last
// multiplier result and builds the WB write port and the SPR write
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_params.svh"

module ex_writeback import ex_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_valid_i,
  input  logic                   wb_ready_i,
  input  logic                   regfile_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,
  input  logic                   lsu_err_i,
  input  spr_sel_t               spr_sel_i,
  input  logic                   dot_spr_i,
  input  logic [`EX_XLEN-1:0]    mult_result_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  output wb_port_t               wb_port_o,
  output logic                   spr_wr_en_o,
  output spr_sel_t               spr_sel_o
);

  logic                   we_q;
  logic [`EX_RADDR_W-1:0] waddr_q;
  spr_sel_t               spr_sel_q;
  logic                   dot_spr_q;
  logic [`EX_XLEN-1:0]    mult_q;    // Product of a fused instruction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q      <= 1'b0;
      waddr_q   <= '0;
      spr_sel_q <= '0;
      dot_spr_q <= 1'b0;
      mult_q    <= '0;
    end else if (ex_valid_i) begin
      we_q      <= regfile_we_i & ~lsu_err_i; // No write after a bus error
      spr_sel_q <= spr_sel_i;
      dot_spr_q <= dot_spr_i;
      mult_q    <= mult_result_i;
      if (!lsu_err_i) begin
        waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      we_q <= 1'b0; // Bubble moves into WB
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // WB port and SPR write
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    wb_port_o.we   = we_q;
    wb_port_o.addr = waddr_q;
    wb_port_o.data = lsu_rdata_i;
    // Fused compute-load writes its product at the load address
    if (dot_spr_q) begin
      wb_port_o.data = mult_q;
    end
  end

  assign spr_wr_en_o = we_q;
  assign spr_sel_o   = spr_sel_q;

endmodule

`default_nettype wire

// File: logic/ex_stage.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage
// ALU, multiplier with dot product and the SPR bank, the ALU forwarding
// port, the branch outputs, the EX/WB register and stage handshake
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_params.svh"

module ex_stage import ex_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  alu_req_t               alu_req_i,
  input  logic                   alu_en_i,
  input  mult_req_t              mult_req_i,
  input  logic                   mult_en_i,
  input  logic                   dot_spr_operand_i,
  input  spr_sel_t               spr_sel_i,
  input  logic                   lsu_en_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   csr_access_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic                   regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                   regfile_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,
  input  logic                   branch_in_ex_i,
  input  logic                   wb_ready_i,
  output wb_port_t               alu_fw_o,
  output wb_port_t               wb_port_o,
  output logic                   branch_decision_o,
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   mult_multicycle_o,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;
  mult_req_t           mult_req;
  logic [`EX_XLEN-1:0] wspr;
  logic [`EX_XLEN-1:0] aspr;
  logic                spr_wr_en;
  spr_sel_t            spr_wr_sel;
  logic                fused;       // Dot product next to a load

  assign fused = dot_spr_operand_i & mult_en_i;

  // SPR operands replace a and b, SDOT only
  always_comb begin
    mult_req = mult_req_i;
    if (dot_spr_operand_i && (mult_req_i.op == MULT_SDOT)) begin
      mult_req.a = aspr;
      mult_req.b = wspr;
    end
  end

  ex_alu alu_i (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  ex_dotp_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (mult_en_i),
    .req_i        (mult_req),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_spr_bank spr_bank_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (spr_wr_en),
    .wr_sel_i  (spr_wr_sel),
    .wr_data_i (lsu_rdata_i),
    .rd_sel_i  (spr_sel_i),
    .wspr_o    (wspr),
    .aspr_o    (aspr)
  );

  ex_writeback writeback_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_o),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_err_i       (lsu_err_i),
    .spr_sel_i       (spr_sel_i),
    .dot_spr_i       (dot_spr_operand_i),
    .mult_result_i   (mult_result),
    .lsu_rdata_i     (lsu_rdata_i),
    .wb_port_o       (wb_port_o),
    .spr_wr_en_o     (spr_wr_en),
    .spr_sel_o       (spr_wr_sel)
  );

  ////////////////////////////////////////////////////////////////////////////
  // ALU forwarding port
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_fw_o.we   = regfile_alu_we_i;
    alu_fw_o.addr = regfile_alu_waddr_i;
    alu_fw_o.data = alu_result;
    if (!fused) begin // Fused product goes out on the WB port instead
      if (mult_en_i) begin
        alu_fw_o.data = mult_result;
      end
      if (csr_access_i) begin
        alu_fw_o.data = csr_rdata_i;
      end
    end
  end

  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = mult_req_i.c; // Target field rides on operand c

  // Branches finish in EX without WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & mult_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

`default_nettype wire

// File: bench/ex_stage_tb.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage testbench
// Random stimulus from a fixed seed, every cycle checked against a
// reference model of the ALU, multiplier, SPR bank and EX/WB register
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_params.svh"

module ex_stage_tb import ex_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 20; // Cycles allowed for a stall to clear

  logic                   clk;
  logic                   rst_n;
  alu_req_t               alu_req;
  logic                   alu_en;
  mult_req_t              mult_req;
  logic                   mult_en;
  logic                   dot_spr;
  spr_sel_t               spr_sel;
  logic                   lsu_en;
  logic                   lsu_ready;
  logic                   lsu_err;
  logic [`EX_XLEN-1:0]    lsu_rdata;
  logic                   csr_access;
  logic [`EX_XLEN-1:0]    csr_rdata;
  logic                   regfile_alu_we;
  logic [`EX_RADDR_W-1:0] regfile_alu_waddr;
  logic                   regfile_we;
  logic [`EX_RADDR_W-1:0] regfile_waddr;
  logic                   branch_in_ex;
  logic                   wb_ready;
  wb_port_t               alu_fw;
  wb_port_t               wb_port;
  logic                   branch_decision;
  logic [`EX_XLEN-1:0]    jump_target;
  logic                   mult_multicycle;
  logic                   ex_ready;
  logic                   ex_valid;

  // Reference model state
  logic [`EX_XLEN-1:0]    wspr_m [`EX_NUM_WSPR];
  logic [`EX_XLEN-1:0]    aspr_m [`EX_NUM_ASPR];
  logic                   wb_we_m;
  logic [`EX_RADDR_W-1:0] wb_addr_m;
  spr_sel_t               wb_sel_m;
  logic                   wb_dot_m;
  logic [`EX_XLEN-1:0]    mult_q_m;
  logic                   mulh_m;

  int          errors;
  int          checks;
  logic        timed_out;
  logic        ready_seen; // ex_ready as sampled in the last cycle
  string       test_name;

  ex_stage ex_stage_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .mult_req_i          (mult_req),
    .mult_en_i           (mult_en),
    .dot_spr_operand_i   (dot_spr),
    .spr_sel_i           (spr_sel),
    .lsu_en_i            (lsu_en),
    .lsu_ready_ex_i      (lsu_ready),
    .lsu_err_i           (lsu_err),
    .lsu_rdata_i         (lsu_rdata),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .branch_in_ex_i      (branch_in_ex),
    .wb_ready_i          (wb_ready),
    .alu_fw_o            (alu_fw),
    .wb_port_o           (wb_port),
    .branch_decision_o   (branch_decision),
    .jump_target_o       (jump_target),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic branch_ref(alu_req_t r);
    case (r.op)
      ALU_EQ:  return r.a == r.b;
      ALU_NE:  return r.a != r.b;
      ALU_LT:  return $signed(r.a) < $signed(r.b);
      ALU_GE:  return $signed(r.a) >= $signed(r.b);
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(alu_req_t r);
    case (r.op)
      ALU_ADD:  return r.a + r.b;
      ALU_SUB:  return r.a - r.b;
      ALU_AND:  return r.a & r.b;
      ALU_OR:   return r.a | r.b;
      ALU_XOR:  return r.a ^ r.b;
      ALU_SLL:  return r.a << r.b[4:0];
      ALU_SLT:  return ($signed(r.a) < $signed(r.b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (r.a < r.b) ? 32'd1 : 32'd0;
      default:  return branch_ref(r) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] mult_ref(mult_op_e op, logic [31:0] a, logic [31:0] b,
                                           logic [31:0] c);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] prod;
    logic signed [31:0] acc;
    logic signed [7:0]  x;
    logic signed [7:0]  y;
    sa   = {{32{a[31]}}, a};
    sb   = {{32{b[31]}}, b};
    prod = sa * sb;
    acc  = c;
    for (int i = 0; i < 4; i++) begin
      x   = a[8*i +: 8];
      y   = b[8*i +: 8];
      acc = acc + x * y;
    end
    case (op)
      MULT_MUL:  return prod[31:0];
      MULT_MULH: return prod[63:32];
      default:   return acc;
    endcase
  endfunction

  task automatic check_word(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_inputs();
    alu_req           = '0;
    alu_en            = 1'b0;
    mult_req          = '0;
    mult_req.c        = $urandom(); // Jump target field
    mult_en           = 1'b0;
    dot_spr           = 1'b0;
    spr_sel           = '0;
    lsu_en            = 1'b0;
    lsu_ready         = 1'b1;
    lsu_err           = 1'b0;
    lsu_rdata         = $urandom();
    csr_access        = 1'b0;
    csr_rdata         = $urandom();
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
  endtask

  task automatic drive_load(logic w_en, logic [1:0] w_idx, logic a_en, logic a_idx);
    idle_inputs();
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = 6'($urandom());
    spr_sel.w_en  = w_en;
    spr_sel.w_idx = w_idx;
    spr_sel.a_en  = a_en;
    spr_sel.a_idx = a_idx;
  endtask

  // SDOT on SPR operands while a load runs
  task automatic drive_fused(logic [1:0] w_idx, logic a_idx);
    drive_load(1'b0, w_idx, 1'b0, a_idx);
    alu_req.op        = alu_op_e'(4'($urandom_range(11, 0)));
    alu_req.a         = $urandom();
    alu_req.b         = $urandom();
    alu_en            = 1'b1;
    regfile_alu_we    = 1'b1;
    regfile_alu_waddr = 6'($urandom());
    mult_req.op       = MULT_SDOT;
    mult_req.a        = $urandom(); // Replaced by the SPRs
    mult_req.b        = $urandom();
    mult_en           = 1'b1;
    dot_spr           = 1'b1;
  endtask

  // Checks outputs late in the cycle, then steps the model over the edge
  task automatic end_cycle();
    logic [31:0] a_op;
    logic [31:0] b_op;
    logic [31:0] mres;
    logic [31:0] fw_exp;
    logic        mc_exp;
    logic        rdy_exp;
    logic        vld_exp;
    #2;
    a_op = mult_req.a;
    b_op = mult_req.b;
    if (dot_spr && mult_req.op == MULT_SDOT) begin
      a_op = aspr_m[spr_sel.a_idx];
      b_op = wspr_m[spr_sel.w_idx];
    end
    mres    = mult_ref(mult_req.op, a_op, b_op, mult_req.c);
    mc_exp  = mult_en && mult_req.op == MULT_MULH && !mulh_m;
    rdy_exp = (!mc_exp && lsu_ready && wb_ready) || branch_in_ex;
    vld_exp = (alu_en || mult_en || csr_access || lsu_en) && !mc_exp && lsu_ready && wb_ready;
    fw_exp  = alu_ref(alu_req);
    if (!(dot_spr && mult_en)) begin
      if (mult_en) fw_exp = mres;
      if (csr_access) fw_exp = csr_rdata; // CSR data wins
    end
    check_bit("alu_fw we", regfile_alu_we, alu_fw.we);
    check_word("alu_fw addr", 32'(regfile_alu_waddr), 32'(alu_fw.addr));
    if (!mc_exp) check_word("alu_fw data", fw_exp, alu_fw.data);
    check_bit("branch decision", branch_ref(alu_req), branch_decision);
    check_word("jump target", mult_req.c, jump_target);
    check_bit("multicycle", mc_exp, mult_multicycle);
    check_bit("ex_ready", rdy_exp, ex_ready);
    check_bit("ex_valid", vld_exp, ex_valid);
    check_bit("wb we", wb_we_m, wb_port.we);
    check_word("wb addr", 32'(wb_addr_m), 32'(wb_port.addr));
    check_word("wb data", wb_dot_m ? mult_q_m : lsu_rdata, wb_port.data);
    ready_seen = ex_ready;
    // SPR write in WB, visible next cycle
    if (wb_we_m && wb_sel_m.w_en) wspr_m[wb_sel_m.w_idx] = lsu_rdata;
    if (wb_we_m && wb_sel_m.a_en) aspr_m[wb_sel_m.a_idx] = lsu_rdata;
    if (vld_exp) begin
      wb_we_m  = regfile_we && !lsu_err;
      wb_sel_m = spr_sel;
      wb_dot_m = dot_spr;
      mult_q_m = mres;
      if (!lsu_err) wb_addr_m = regfile_waddr;
    end else if (wb_ready) begin
      wb_we_m = 1'b0;
    end
    if (mc_exp) mulh_m = 1'b1;
    else if (rdy_exp) mulh_m = 1'b0;
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic alu_forwarding();
    test_name = "alu_fw";
    for (int i = 0; i < 200; i++) begin
      idle_inputs();
      alu_req.op        = alu_op_e'(4'($urandom_range(11, 0)));
      alu_req.a         = $urandom();
      alu_req.b         = $urandom();
      alu_en            = 1'b1;
      regfile_alu_we    = 1'($urandom());
      regfile_alu_waddr = 6'($urandom());
      csr_access        = ($urandom_range(3, 0) == 0);
      lsu_ready         = ($urandom_range(7, 0) != 0); // LSU stall now and then
      end_cycle();
    end
  endtask

  task automatic branch_compares();
    test_name = "branch";
    for (int i = 0; i < 100; i++) begin
      idle_inputs();
      alu_req.op   = alu_op_e'(4'(8 + $urandom_range(3, 0))); // EQ, NE, LT, GE
      alu_req.a    = $urandom();
      alu_req.b    = ($urandom_range(1, 0) == 1) ? alu_req.a : $urandom();
      alu_en       = 1'b1;
      branch_in_ex = 1'b1;
      lsu_ready    = 1'($urandom()); // Branch frees EX even on a stall
      end_cycle();
    end
  endtask

  task automatic multiplier_ops();
    int stalls;
    test_name = "mult";
    for (int i = 0; i < 60; i++) begin
      idle_inputs();
      mult_req.op       = ($urandom_range(1, 0) == 1) ? MULT_SDOT : MULT_MUL;
      mult_req.a        = $urandom();
      mult_req.b        = $urandom();
      mult_en           = 1'b1;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = 6'($urandom());
      end_cycle();
    end
    test_name = "mulh";
    for (int i = 0; i < 20; i++) begin
      idle_inputs();
      mult_req.op    = MULT_MULH;
      mult_req.a     = $urandom();
      mult_req.b     = $urandom();
      mult_en        = 1'b1;
      regfile_alu_we = 1'b1;
      stalls         = 0;
      end_cycle(); // Operands held until the stage is ready
      while (ready_seen !== 1'b1) begin
        if (stalls == TIMEOUT) begin
          errors++;
          timed_out = 1'b1;
          $display("Timeout in %s: ex_ready stayed low after a MULH", test_name);
          return;
        end
        stalls++;
        end_cycle();
      end
      check_word("stall cycles", 32'd1, 32'(stalls));
    end
  endtask

  task automatic spr_dot_products();
    for (int r = 0; r < 10; r++) begin
      test_name = "spr_load";
      for (int i = 0; i < 6; i++) begin
        drive_load(1'($urandom()), 2'($urandom()), 1'($urandom()), 1'($urandom()));
        end_cycle();
      end
      test_name = "fused_dot";
      drive_fused(2'($urandom()), 1'($urandom()));
      end_cycle();
      idle_inputs();
      end_cycle(); // Product on the WB port
    end
  endtask

  task automatic load_errors();
    logic [1:0] w_idx;
    logic       a_idx;
    test_name = "load_err";
    for (int i = 0; i < 10; i++) begin
      w_idx = 2'($urandom());
      a_idx = 1'($urandom());
      drive_load(1'b1, w_idx, 1'b1, a_idx);
      lsu_err = 1'b1;
      end_cycle();
      idle_inputs();
      end_cycle(); // Bad load in WB, SPRs stay as they were
      drive_fused(w_idx, a_idx); // Old SPR values must be used
      end_cycle();
      idle_inputs();
      end_cycle();
    end
  endtask

  task automatic back_pressure();
    int hold;
    test_name = "backpressure";
    for (int i = 0; i < 15; i++) begin
      drive_load(1'b0, 2'd0, 1'b0, 1'b0);
      end_cycle();
      hold = $urandom_range(5, 1);
      drive_load(1'b0, 2'd0, 1'b0, 1'b0);
      for (int k = 0; k < hold; k++) begin
        wb_ready  = 1'b0;
        lsu_rdata = $urandom();
        end_cycle();
      end
      wb_ready = 1'b1; // Same load now leaves EX
      end_cycle();
      idle_inputs();
      end_cycle();
    end
  endtask

  initial begin
    void'($urandom(32'he08));
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    rst_n     = 1'b0;
    idle_inputs();
    for (int i = 0; i < `EX_NUM_WSPR; i++) wspr_m[i] = '0;
    for (int i = 0; i < `EX_NUM_ASPR; i++) aspr_m[i] = '0;
    wb_we_m   = 1'b0;
    wb_addr_m = '0;
    wb_sel_m  = '0;
    wb_dot_m  = 1'b0;
    mult_q_m  = '0;
    mulh_m    = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    alu_forwarding();
    branch_compares();
    multiplier_ops();
    if (!timed_out) begin
      spr_dot_products();
      load_errors();
      back_pressure();
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_dotp_mult.sv
logic/ex_spr_bank.sv
logic/ex_writeback.sv
logic/ex_stage.sv
bench/ex_stage_tb.sv

// File: run.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module ex_stage_tb \
  --Mdir obj_dir -o ex_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ex_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
